/* rtl/decode_issue.sv */
// decode issue: registers the decoded bundle and runs the four-phase output handshake
`timescale 1ns/1ps
`default_nettype none

module decode_issue
  import decode_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        slot_valid_i,
  input  logic        stall_i,
  input  logic        dec_ack_i,
  input  logic [3:0]  class_i,
  input  logic [4:0]  op_i,
  input  word_t       op1_i,
  input  word_t       op2_i,
  input  logic        rd_we_i,
  input  reg_addr_t   rd_i,
  input  word_t       pc_i,
  input  logic [2:0]  mem_size_i,
  input  logic [11:0] mem_offset_i,
  input  word_t       jump_target_i,
  output logic        slot_take_o,
  output logic        dec_req_o,
  output logic [3:0]  dec_class_o,
  output logic [4:0]  dec_op_o,
  output word_t       dec_op1_o,
  output word_t       dec_op2_o,
  output logic        dec_rd_we_o,
  output reg_addr_t   dec_rd_addr_o,
  output word_t       dec_pc_o,
  output logic [2:0]  dec_mem_size_o,
  output logic [11:0] dec_mem_offset_o,
  output word_t       dec_jump_target_o,
  output logic        dec_redirect_o
);

  // consumer must have dropped its ack from the last bundle
  assign slot_take_o = slot_valid_i && !stall_i && !dec_req_o && !dec_ack_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      dec_req_o      <= 1'b0;
      dec_redirect_o <= 1'b0;
    end else if (slot_take_o) begin
      dec_req_o      <= 1'b1;
      dec_redirect_o <= class_i == cls_jalr;
    end else if (dec_ack_i) begin
      dec_req_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (slot_take_o) begin
      dec_class_o       <= class_i;
      dec_op_o          <= op_i;
      dec_op1_o         <= op1_i;
      dec_op2_o         <= op2_i;
      dec_rd_we_o       <= rd_we_i;
      dec_rd_addr_o     <= rd_i;
      dec_pc_o          <= pc_i;
      dec_mem_size_o    <= mem_size_i;
      dec_mem_offset_o  <= mem_offset_i;
      dec_jump_target_o <= jump_target_i;
    end
  end

  bundle_stable: assert property (@(posedge clk) disable iff (reset_i)
    dec_req_o && !dec_ack_i |=> $stable({dec_class_o, dec_op_o, dec_op1_o, dec_op2_o,
      dec_rd_we_o, dec_rd_addr_o, dec_pc_o, dec_mem_size_o, dec_mem_offset_o,
      dec_jump_target_o, dec_redirect_o}));

  // a stalled slot must stay put in the capture stage
  no_take_on_stall: assert property (@(posedge clk) disable iff (reset_i)
    stall_i |-> !slot_take_o);

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
// decode package: shared widths, instruction classes, ALU ops and RISC-V major opcodes
`default_nettype none

package decode_pkg;

  localparam int xlen = 64;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     inst_t;
  typedef logic [xlen-1:0] word_t;

  typedef enum logic [3:0] {
    cls_reg_imm,
    cls_reg_imm_w,
    cls_reg_reg,
    cls_reg_reg_w,
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_illegal
  } inst_class_e;

  // word forms share add/sub/shift codes, the class marks them
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu,
    alu_nop
  } alu_op_e;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;

endpackage

`default_nettype wire

/* rtl/decode_stage.sv */
// decode stage top: capture, decode, register read, operand select and issue
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        inst_req_i,
  output logic        inst_ack_o,
  input  logic [31:0] inst_i,
  input  logic [63:0] pc_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_addr_i,
  input  logic [63:0] wb_data_i,
  input  logic        ex_rd_we_i,
  input  logic [4:0]  ex_rd_addr_i,
  input  logic [63:0] ex_rd_data_i,
  input  logic        ex_is_load_i,
  input  logic        mem_rd_we_i,
  input  logic [4:0]  mem_rd_addr_i,
  input  logic [63:0] mem_rd_data_i,
  output logic        stall_o,
  output logic        dec_req_o,
  input  logic        dec_ack_i,
  output logic [3:0]  dec_class_o,
  output logic [4:0]  dec_op_o,
  output logic [63:0] dec_op1_o,
  output logic [63:0] dec_op2_o,
  output logic        dec_rd_we_o,
  output logic [4:0]  dec_rd_addr_o,
  output logic [63:0] dec_pc_o,
  output logic [2:0]  dec_mem_size_o,
  output logic [11:0] dec_mem_offset_o,
  output logic [63:0] dec_jump_target_o,
  output logic        dec_redirect_o
);

  logic        slot_valid;
  logic        slot_take;
  logic [31:0] slot_inst;
  logic [63:0] slot_pc;
  logic [3:0]  inst_class;
  logic [4:0]  alu_op;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic        use_rs1;
  logic        use_rs2;
  logic        rd_we;
  logic [2:0]  mem_size;
  logic [11:0] imm_i;
  logic [11:0] imm_s;
  logic [19:0] imm_u;
  logic [4:0]  rf_rs1_addr;
  logic [4:0]  rf_rs2_addr;
  logic [63:0] rf_rs1_data;
  logic [63:0] rf_rs2_data;
  logic [63:0] op1;
  logic [63:0] op2;
  logic [11:0] mem_offset;
  logic [63:0] jump_target;

  inst_capture capture_i (
    .clk, .reset_i, .inst_req_i, .inst_i, .pc_i,
    .slot_take_i (slot_take),
    .inst_ack_o,
    .slot_valid_o (slot_valid),
    .slot_inst_o  (slot_inst),
    .slot_pc_o    (slot_pc)
  );

  inst_decoder decoder_i (
    .slot_inst_i (slot_inst),
    .class_o     (inst_class),
    .op_o        (alu_op),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .use_rs1_o   (use_rs1),
    .use_rs2_o   (use_rs2),
    .rd_we_o     (rd_we),
    .mem_size_o  (mem_size),
    .imm_i_o     (imm_i),
    .imm_s_o     (imm_s),
    .imm_u_o     (imm_u)
  );

  reg_file reg_file_i (
    .clk, .reset_i, .wb_we_i, .wb_addr_i, .wb_data_i,
    .rs1_addr_i (rf_rs1_addr),
    .rs2_addr_i (rf_rs2_addr),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data)
  );

  operand_select operand_select_i (
    .slot_valid_i (slot_valid),
    .slot_pc_i    (slot_pc),
    .class_i      (inst_class),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .use_rs1_i    (use_rs1),
    .use_rs2_i    (use_rs2),
    .imm_i_i      (imm_i),
    .imm_s_i      (imm_s),
    .imm_u_i      (imm_u),
    .rs1_data_i   (rf_rs1_data),
    .rs2_data_i   (rf_rs2_data),
    .ex_rd_we_i, .ex_rd_addr_i, .ex_rd_data_i, .ex_is_load_i,
    .mem_rd_we_i, .mem_rd_addr_i, .mem_rd_data_i,
    .rs1_addr_o    (rf_rs1_addr),
    .rs2_addr_o    (rf_rs2_addr),
    .op1_o         (op1),
    .op2_o         (op2),
    .mem_offset_o  (mem_offset),
    .jump_target_o (jump_target),
    .stall_o
  );

  decode_issue issue_i (
    .clk, .reset_i,
    .slot_valid_i  (slot_valid),
    .stall_i       (stall_o),
    .dec_ack_i,
    .class_i       (inst_class),
    .op_i          (alu_op),
    .op1_i         (op1),
    .op2_i         (op2),
    .rd_we_i       (rd_we),
    .rd_i          (rd),
    .pc_i          (slot_pc),
    .mem_size_i    (mem_size),
    .mem_offset_i  (mem_offset),
    .jump_target_i (jump_target),
    .slot_take_o   (slot_take),
    .dec_req_o, .dec_class_o, .dec_op_o, .dec_op1_o, .dec_op2_o,
    .dec_rd_we_o, .dec_rd_addr_o, .dec_pc_o, .dec_mem_size_o,
    .dec_mem_offset_o, .dec_jump_target_o, .dec_redirect_o
  );

endmodule

`default_nettype wire

/* rtl/inst_capture.sv */
// instruction capture: four-phase input handshake into a one-entry instruction slot
`timescale 1ns/1ps
`default_nettype none

module inst_capture
  import decode_pkg::*;
(
  input  logic  clk,
  input  logic  reset_i,
  input  logic  inst_req_i,
  input  inst_t inst_i,
  input  word_t pc_i,
  input  logic  slot_take_i,
  output logic  inst_ack_o,
  output logic  slot_valid_o,
  output inst_t slot_inst_o,
  output word_t slot_pc_o
);

  logic load;

  // new request, previous handshake finished, slot free
  assign load = inst_req_i && !inst_ack_o && !slot_valid_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      inst_ack_o   <= 1'b0;
      slot_valid_o <= 1'b0;
    end else if (load) begin
      inst_ack_o   <= 1'b1;
      slot_valid_o <= 1'b1;
    end else begin
      if (!inst_req_i) begin
        inst_ack_o <= 1'b0;
      end
      if (slot_take_i) begin
        slot_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slot_inst_o <= inst_i;
      slot_pc_o   <= pc_i;
    end
  end

  // producer keeps the request up until the acknowledge arrives
  ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
    $rose(inst_ack_o) |-> inst_req_i);

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
// instruction decoder: class, ALU op, register fields, immediates and register-use flags
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import decode_pkg::*;
(
  input  inst_t       slot_inst_i,
  output inst_class_e class_o,
  output alu_op_e     op_o,
  output reg_addr_t   rs1_o,
  output reg_addr_t   rs2_o,
  output reg_addr_t   rd_o,
  output logic        use_rs1_o,
  output logic        use_rs2_o,
  output logic        rd_we_o,
  output logic [2:0]  mem_size_o,
  output logic [11:0] imm_i_o,
  output logic [11:0] imm_s_o,
  output logic [19:0] imm_u_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  logic       alt_ok;
  logic       bad;

  assign opcode  = slot_inst_i[6:0];
  assign funct3  = slot_inst_i[14:12];
  assign funct7  = slot_inst_i[31:25];
  assign f7_zero = funct7 == 7'b0000000;
  assign f7_alt  = funct7 == 7'b0100000;
  // only add and srl have an alternate form
  assign alt_ok  = funct3 == 3'b000 || funct3 == 3'b101;

  assign rs1_o   = slot_inst_i[19:15];
  assign rs2_o   = slot_inst_i[24:20];
  assign rd_o    = slot_inst_i[11:7];
  assign imm_i_o = slot_inst_i[31:20];
  assign imm_s_o = {slot_inst_i[31:25], slot_inst_i[11:7]};
  assign imm_u_o = slot_inst_i[31:12];

  function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
    alu_op_e r;
    case (f3)
      3'b000:  r = alu_add;
      3'b001:  r = alu_sll;
      3'b010:  r = alu_slt;
      3'b011:  r = alu_sltu;
      3'b100:  r = alu_xor;
      3'b101:  r = alu_srl;
      3'b110:  r = alu_or;
      default: r = alu_and;
    endcase
    if (alt && r == alu_add) begin
      r = alu_sub;
    end
    if (alt && r == alu_srl) begin
      r = alu_sra;
    end
    return r;
  endfunction

  always_comb begin
    class_o = cls_illegal;
    op_o    = alu_add;
    bad     = 1'b0;
    case (opcode)
      opc_op_imm: begin
        class_o = cls_reg_imm;
        op_o    = f3_op(funct3, funct3 == 3'b101 && funct7[5]);
        // rv64 shifts take a 6-bit shamt
        if (funct3 == 3'b001) begin
          bad = funct7[6:1] != 6'b000000;
        end
        if (funct3 == 3'b101) begin
          bad = funct7[6:1] != 6'b000000 && funct7[6:1] != 6'b010000;
        end
      end
      opc_op_imm_32: begin
        class_o = cls_reg_imm_w;
        op_o    = f3_op(funct3, funct3 == 3'b101 && funct7[5]);
        case (funct3)
          3'b000:  bad = 1'b0;
          3'b001:  bad = !f7_zero;
          3'b101:  bad = !(f7_zero || f7_alt);
          default: bad = 1'b1;
        endcase
      end
      opc_op: begin
        class_o = cls_reg_reg;
        op_o    = f3_op(funct3, funct7[5]);
        bad     = !(f7_zero || (f7_alt && alt_ok));
      end
      opc_op_32: begin
        class_o = cls_reg_reg_w;
        op_o    = f3_op(funct3, funct7[5]);
        bad     = !(f7_zero || (f7_alt && alt_ok)) || !(alt_ok || funct3 == 3'b001);
      end
      opc_lui:   class_o = cls_lui;
      opc_auipc: class_o = cls_auipc;
      opc_jal:   class_o = cls_jal;
      opc_jalr: begin
        class_o = cls_jalr;
        bad     = funct3 != 3'b000;
      end
      opc_branch: begin
        class_o = cls_branch;
        case (funct3)
          3'b000:  op_o = alu_beq;
          3'b001:  op_o = alu_bne;
          3'b100:  op_o = alu_blt;
          3'b101:  op_o = alu_bge;
          3'b110:  op_o = alu_bltu;
          3'b111:  op_o = alu_bgeu;
          default: bad = 1'b1;
        endcase
      end
      opc_load: begin
        class_o = cls_load;
        bad     = funct3 == 3'b111;
      end
      opc_store: begin
        class_o = cls_store;
        bad     = funct3[2];
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      class_o = cls_illegal;
      op_o    = alu_nop;
    end
  end

  assign use_rs1_o  = !(class_o inside {cls_lui, cls_auipc, cls_jal, cls_illegal});
  assign use_rs2_o  = class_o inside {cls_reg_reg, cls_reg_reg_w, cls_branch, cls_store};
  assign rd_we_o    = rd_o != '0 && !(class_o inside {cls_branch, cls_store, cls_illegal});
  assign mem_size_o = (class_o inside {cls_load, cls_store}) ? funct3 : 3'b000;

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
// operand select: forwarding, operand choice, load-use stall, memory offset and jalr target
`timescale 1ns/1ps
`default_nettype none

module operand_select
  import decode_pkg::*;
(
  input  logic        slot_valid_i,
  input  word_t       slot_pc_i,
  input  logic [3:0]  class_i,
  input  reg_addr_t   rs1_i,
  input  reg_addr_t   rs2_i,
  input  logic        use_rs1_i,
  input  logic        use_rs2_i,
  input  logic [11:0] imm_i_i,
  input  logic [11:0] imm_s_i,
  input  logic [19:0] imm_u_i,
  input  word_t       rs1_data_i,
  input  word_t       rs2_data_i,
  input  logic        ex_rd_we_i,
  input  reg_addr_t   ex_rd_addr_i,
  input  word_t       ex_rd_data_i,
  input  logic        ex_is_load_i,
  input  logic        mem_rd_we_i,
  input  reg_addr_t   mem_rd_addr_i,
  input  word_t       mem_rd_data_i,
  output reg_addr_t   rs1_addr_o,
  output reg_addr_t   rs2_addr_o,
  output word_t       op1_o,
  output word_t       op2_o,
  output logic [11:0] mem_offset_o,
  output word_t       jump_target_o,
  output logic        stall_o
);

  word_t src1;
  word_t src2;
  word_t imm_i_ext;
  word_t imm_u_ext;
  word_t jalr_sum;
  logic  hit1;
  logic  hit2;

  assign rs1_addr_o = rs1_i;
  assign rs2_addr_o = rs2_i;
  assign imm_i_ext  = {{(xlen-12){imm_i_i[11]}}, imm_i_i};
  assign imm_u_ext  = {{(xlen-32){imm_u_i[19]}}, imm_u_i, 12'b0};

  // ex result is newer than mem, so it wins
  function automatic word_t forward(input reg_addr_t addr, input word_t rf_data);
    if (addr == '0) begin
      return '0;
    end
    if (ex_rd_we_i && ex_rd_addr_i == addr) begin
      return ex_rd_data_i;
    end
    if (mem_rd_we_i && mem_rd_addr_i == addr) begin
      return mem_rd_data_i;
    end
    return rf_data;
  endfunction

  always_comb begin
    src1 = forward(rs1_i, rs1_data_i);
    src2 = forward(rs2_i, rs2_data_i);
  end

  always_comb begin
    if (use_rs1_i) begin
      op1_o = src1;
    end else if (class_i == cls_auipc || class_i == cls_jal) begin
      op1_o = slot_pc_i;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    if (use_rs2_i) begin
      op2_o = src2;
    end else if (class_i inside {cls_reg_imm, cls_reg_imm_w, cls_load, cls_jalr}) begin
      op2_o = imm_i_ext;
    end else if (class_i == cls_lui || class_i == cls_auipc) begin
      op2_o = imm_u_ext;
    end else if (class_i == cls_jal) begin
      op2_o = slot_pc_i;
    end else begin
      op2_o = '0;
    end
  end

  assign mem_offset_o = (class_i == cls_load)  ? imm_i_i :
                        (class_i == cls_store) ? imm_s_i : 12'b0;

  assign jalr_sum      = op1_o + imm_i_ext;
  assign jump_target_o = (class_i == cls_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : '0;

  // load in ex has no data yet
  assign hit1    = use_rs1_i && rs1_i != '0 && rs1_i == ex_rd_addr_i;
  assign hit2    = use_rs2_i && rs2_i != '0 && rs2_i == ex_rd_addr_i;
  assign stall_o = slot_valid_i && ex_is_load_i && (hit1 || hit2);

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// register file: x1..x31, two read ports with write-through, one writeback port
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      reset_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_addr_i,
  input  word_t     wb_data_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we_i && wb_addr_i != '0) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    // same-cycle write goes straight through
    if (wb_we_i && wb_addr_i == addr) begin
      return wb_data_i;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
rtl/decode_pkg.sv
rtl/inst_capture.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/operand_select.sv
rtl/decode_issue.sv
rtl/decode_stage.sv
test/tb_decode_stage.sv

/* test/decode_model.svh */
// decode reference model: expected output bundle for one instruction from the ISA rules
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
  logic [3:0]  cls;
  logic [4:0]  op;
  logic [63:0] op1;
  logic [63:0] op2;
  logic        rd_we;
  logic [4:0]  rd;
  logic [63:0] pc;
  logic [2:0]  mem_size;
  logic [11:0] mem_offset;
  logic [63:0] jump_target;
  logic        redirect;
} bundle_t;

function automatic logic [63:0] sext12(input logic [11:0] v);
  return {{52{v[11]}}, v};
endfunction

// ex beats mem, x0 is always zero
function automatic logic [63:0] source_value(input logic [4:0] addr);
  if (addr == 5'd0) begin
    return 64'd0;
  end
  if (ex_rd_we_i && ex_rd_addr_i == addr) begin
    return ex_rd_data_i;
  end
  if (mem_rd_we_i && mem_rd_addr_i == addr) begin
    return mem_rd_data_i;
  end
  return rf_model[addr];
endfunction

function automatic logic [4:0] arith_op(input logic [2:0] f3, input logic alt);
  case (f3)
    3'b000:  return alt ? alu_sub : alu_add;
    3'b001:  return alu_sll;
    3'b010:  return alu_slt;
    3'b011:  return alu_sltu;
    3'b100:  return alu_xor;
    3'b101:  return alt ? alu_sra : alu_srl;
    3'b110:  return alu_or;
    default: return alu_and;
  endcase
endfunction

function automatic bundle_t decode_model(input logic [31:0] inst, input logic [63:0] pc);
  bundle_t     b;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] imm_u;
  logic [63:0] sum;
  logic        legal;
  logic        use1;
  logic        use2;
  opc   = inst[6:0];
  f3    = inst[14:12];
  f7    = inst[31:25];
  imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
  b     = '0;
  b.rd  = inst[11:7];
  b.pc  = pc;
  b.op  = alu_add;
  legal = 1'b1;
  use1  = 1'b1;
  use2  = 1'b0;
  case (opc)
    opc_op_imm: begin
      b.cls = cls_reg_imm;
      b.op  = arith_op(f3, f3 == 3'b101 && inst[30]);
      if (f3 == 3'b001) legal = inst[31:26] == 6'b000000;
      if (f3 == 3'b101) legal = inst[31:26] == 6'b000000 || inst[31:26] == 6'b010000;
    end
    opc_op_imm_32: begin
      b.cls = cls_reg_imm_w;
      b.op  = arith_op(f3, f3 == 3'b101 && inst[30]);
      legal = f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'h00) ||
              (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
    end
    opc_op, opc_op_32: begin
      b.cls = (opc == opc_op) ? cls_reg_reg : cls_reg_reg_w;
      b.op  = arith_op(f3, f7 == 7'h20);
      use2  = 1'b1;
      legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      if (opc == opc_op_32 && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) legal = 1'b0;
    end
    opc_lui: begin
      b.cls = cls_lui;
      use1  = 1'b0;
    end
    opc_auipc: begin
      b.cls = cls_auipc;
      use1  = 1'b0;
    end
    opc_jal: begin
      b.cls = cls_jal;
      use1  = 1'b0;
    end
    opc_jalr: begin
      b.cls = cls_jalr;
      legal = f3 == 3'b000;
    end
    opc_branch: begin
      b.cls = cls_branch;
      use2  = 1'b1;
      case (f3)
        3'b000:  b.op = alu_beq;
        3'b001:  b.op = alu_bne;
        3'b100:  b.op = alu_blt;
        3'b101:  b.op = alu_bge;
        3'b110:  b.op = alu_bltu;
        3'b111:  b.op = alu_bgeu;
        default: legal = 1'b0;
      endcase
    end
    opc_load: begin
      b.cls = cls_load;
      legal = f3 != 3'b111;
    end
    opc_store: begin
      b.cls = cls_store;
      use2  = 1'b1;
      legal = f3[2] == 1'b0;
    end
    default: legal = 1'b0;
  endcase
  if (!legal) begin
    b.cls = cls_illegal;
    b.op  = alu_nop;
    return b;
  end
  b.rd_we = inst[11:7] != 5'd0 && b.cls != cls_branch && b.cls != cls_store;
  if (b.cls == cls_load || b.cls == cls_store) b.mem_size = f3;
  if (use1) b.op1 = source_value(inst[19:15]);
  else if (b.cls == cls_auipc || b.cls == cls_jal) b.op1 = pc;
  if (use2) b.op2 = source_value(inst[24:20]);
  else if (b.cls == cls_reg_imm || b.cls == cls_reg_imm_w || b.cls == cls_load ||
           b.cls == cls_jalr) b.op2 = sext12(inst[31:20]);
  else if (b.cls == cls_lui || b.cls == cls_auipc) b.op2 = imm_u;
  else if (b.cls == cls_jal) b.op2 = pc;
  if (b.cls == cls_load) b.mem_offset = inst[31:20];
  if (b.cls == cls_store) b.mem_offset = {inst[31:25], inst[11:7]};
  if (b.cls == cls_jalr) begin
    sum           = b.op1 + sext12(inst[31:20]);
    b.jump_target = {sum[63:1], 1'b0};
    b.redirect    = 1'b1;
  end
  return b;
endfunction

`endif

/* test/tb_decode_stage.sv */
// decode stage testbench: random and directed instructions checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
  import decode_pkg::*;
();

  localparam int clk_period      = 4;
  localparam int n_imm           = 40;
  localparam int n_reg           = 24;
  localparam int n_ctrl          = 40;
  localparam int n_burst         = 60;
  localparam int n_directed      = 12;
  localparam int total_insts     = n_imm + n_reg + n_ctrl + n_burst + n_directed;
  localparam int watchdog_cycles = total_insts * 60 + 200;

  logic        clk;
  logic        reset_i;
  logic        inst_req_i;
  logic        inst_ack_o;
  logic [31:0] inst_i;
  logic [63:0] pc_i;
  logic        wb_we_i;
  logic [4:0]  wb_addr_i;
  logic [63:0] wb_data_i;
  logic        ex_rd_we_i;
  logic [4:0]  ex_rd_addr_i;
  logic [63:0] ex_rd_data_i;
  logic        ex_is_load_i;
  logic        mem_rd_we_i;
  logic [4:0]  mem_rd_addr_i;
  logic [63:0] mem_rd_data_i;
  logic        stall_o;
  logic        dec_req_o;
  logic        dec_ack_i;
  logic [3:0]  dec_class_o;
  logic [4:0]  dec_op_o;
  logic [63:0] dec_op1_o;
  logic [63:0] dec_op2_o;
  logic        dec_rd_we_o;
  logic [4:0]  dec_rd_addr_o;
  logic [63:0] dec_pc_o;
  logic [2:0]  dec_mem_size_o;
  logic [11:0] dec_mem_offset_o;
  logic [63:0] dec_jump_target_o;
  logic        dec_redirect_o;

  integer      seed = 32'hd20c_71e5;
  logic [63:0] rf_model [0:31];
  int          mismatches;
  int          protocol_errs;
  logic        ack_prev;

  `include "decode_model.svh"

  bundle_t expected_q [$];

  logic [6:0] known_opc [11] = '{opc_op_imm, opc_op_imm_32, opc_op, opc_op_32, opc_lui,
    opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load, opc_store};

  decode_stage dut_i (
    .clk, .reset_i, .inst_req_i, .inst_ack_o, .inst_i, .pc_i,
    .wb_we_i, .wb_addr_i, .wb_data_i,
    .ex_rd_we_i, .ex_rd_addr_i, .ex_rd_data_i, .ex_is_load_i,
    .mem_rd_we_i, .mem_rd_addr_i, .mem_rd_data_i,
    .stall_o, .dec_req_o, .dec_ack_i, .dec_class_o, .dec_op_o, .dec_op1_o, .dec_op2_o,
    .dec_rd_we_o, .dec_rd_addr_o, .dec_pc_o, .dec_mem_size_o, .dec_mem_offset_o,
    .dec_jump_target_o, .dec_redirect_o
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic is_known(input logic [6:0] opc);
    foreach (known_opc[k]) begin
      if (known_opc[k] == opc) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic [6:0] unknown_opcode();
    logic [31:0] r;
    do r = $random(seed); while (is_known(r[6:0]));
    return r[6:0];
  endfunction

  // random fields, with shift and funct7 bits pulled toward legal encodings
  function automatic logic [31:0] random_inst(input logic [6:0] opc);
    logic [31:0] r;
    r      = $random(seed);
    r[6:0] = opc;
    if ((opc == opc_op_imm || opc == opc_op_imm_32) && r[13:12] == 2'b01) begin
      r[31]    = 1'b0;
      r[29:26] = 4'b0000;
      if (opc == opc_op_imm_32) r[25] = 1'b0;
    end
    if (opc == opc_op || opc == opc_op_32) r[31:25] = {1'b0, r[30], 5'b00000};
    return r;
  endfunction

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic wait_idle();
    while (expected_q.size() != 0 || dec_req_o || dec_ack_i) @(posedge clk);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    wait_idle();
    @(posedge clk);
    wb_we_i   <= 1'b1;
    wb_addr_i <= addr;
    wb_data_i <= data;
    @(posedge clk);
    wb_we_i <= 1'b0;
    if (addr != 5'd0) rf_model[addr] = data;
  endtask

  task automatic set_forwarding(input logic ex_we, input logic [4:0] ex_addr,
                                input logic [63:0] ex_data, input logic ex_load,
                                input logic mem_we, input logic [4:0] mem_addr,
                                input logic [63:0] mem_data);
    wait_idle();
    @(posedge clk);
    ex_rd_we_i    <= ex_we;
    ex_rd_addr_i  <= ex_addr;
    ex_rd_data_i  <= ex_data;
    ex_is_load_i  <= ex_load;
    mem_rd_we_i   <= mem_we;
    mem_rd_addr_i <= mem_addr;
    mem_rd_data_i <= mem_data;
    @(posedge clk);
  endtask

  task automatic send_inst(input logic [31:0] inst, input logic [63:0] pc);
    expected_q.push_back(decode_model(inst, pc));
    @(posedge clk);
    inst_req_i <= 1'b1;
    inst_i     <= inst;
    pc_i       <= pc;
    do @(posedge clk); while (!inst_ack_o);
    // producer may take a few cycles to see the acknowledge
    repeat ({$random(seed)} % 3) @(posedge clk);
    inst_req_i <= 1'b0;
    do @(posedge clk); while (inst_ack_o);
  endtask

  // writeback is sampled on the same edge that issues the instruction
  task automatic send_with_writeback(input logic [31:0] inst, input logic [4:0] addr,
                                     input logic [63:0] data);
    wait_idle();
    rf_model[addr] = data;
    expected_q.push_back(decode_model(inst, 64'h1000));
    @(posedge clk);
    inst_req_i <= 1'b1;
    inst_i     <= inst;
    pc_i       <= 64'h1000;
    @(posedge clk);
    wb_we_i   <= 1'b1;
    wb_addr_i <= addr;
    wb_data_i <= data;
    do @(posedge clk); while (!inst_ack_o);
    wb_we_i    <= 1'b0;
    inst_req_i <= 1'b0;
    do @(posedge clk); while (inst_ack_o);
  endtask

  task automatic stall_on_load(input logic [31:0] inst, input logic [4:0] load_rd);
    set_forwarding(1'b1, load_rd, random_word(), 1'b1, 1'b0, 5'd0, 64'd0);
    send_inst(inst, 64'h2000);
    repeat (3) begin
      @(posedge clk);
      check_equal(stall_o, 1'b1, "stall_o on load-use");
      check_equal(dec_req_o, 1'b0, "dec_req_o during stall");
    end
    ex_is_load_i <= 1'b0;
    wait_idle();
  endtask

  initial begin
    reset_i      = 1'b1;
    inst_req_i   = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    wb_we_i      = 1'b0;
    wb_addr_i    = '0;
    wb_data_i    = '0;
    ex_rd_we_i   = 1'b0;
    ex_rd_addr_i = '0;
    ex_rd_data_i = '0;
    ex_is_load_i = 1'b0;
    mem_rd_we_i  = 1'b0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    dec_ack_i    = 1'b0;
    mismatches   = 0;
    protocol_errs = 0;
    foreach (rf_model[k]) rf_model[k] = '0;
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);

    // x0 write must be dropped
    for (int r = 0; r < 32; r++) write_reg(r, random_word());

    for (int n = 0; n < n_imm; n++) begin
      send_inst(random_inst(known_opc[{$random(seed)} % 6]), random_word() & ~64'h3);
    end
    for (int n = 0; n < n_reg; n++) begin
      send_inst(random_inst(known_opc[2 + {$random(seed)} % 2]), random_word() & ~64'h3);
    end
    send_with_writeback({7'h00, 5'd6, 5'd5, 3'b000, 5'd7, opc_op}, 5'd5, random_word());
    send_with_writeback({7'h20, 5'd6, 5'd5, 3'b000, 5'd7, opc_op_32}, 5'd6, random_word());

    // forwarding priority
    set_forwarding(1'b1, 5'd3, random_word(), 1'b0, 1'b1, 5'd3, random_word());
    send_inst({7'h00, 5'd4, 5'd3, 3'b000, 5'd8, opc_op}, 64'h100);
    set_forwarding(1'b0, 5'd3, random_word(), 1'b0, 1'b1, 5'd3, random_word());
    send_inst({7'h00, 5'd4, 5'd3, 3'b000, 5'd8, opc_op}, 64'h104);
    set_forwarding(1'b1, 5'd9, random_word(), 1'b0, 1'b1, 5'd4, random_word());
    send_inst({7'h00, 5'd4, 5'd3, 3'b000, 5'd8, opc_op}, 64'h108);
    set_forwarding(1'b1, 5'd0, random_word(), 1'b0, 1'b1, 5'd0, random_word());
    send_inst({7'h00, 5'd0, 5'd0, 3'b000, 5'd8, opc_op}, 64'h10c);

    stall_on_load({7'h00, 5'd2, 5'd10, 3'b000, 5'd11, opc_op}, 5'd10);
    stall_on_load({7'h20, 5'd12, 5'd1, 3'b000, 5'd13, opc_op}, 5'd12);
    set_forwarding(1'b0, 5'd0, 64'd0, 1'b0, 1'b0, 5'd0, 64'd0);

    for (int n = 0; n < n_ctrl; n++) begin
      if ({$random(seed)} % 8 == 0) send_inst(random_inst(unknown_opcode()), random_word());
      else send_inst(random_inst(known_opc[6 + {$random(seed)} % 5]), random_word() & ~64'h3);
    end
    send_inst({12'h001, 5'd5, 3'b000, 5'd1, opc_jalr}, 64'h3000);
    send_inst({12'hfff, 5'd7, 3'b000, 5'd0, opc_jalr}, 64'h3004);
    send_inst({20'h12345, 5'd0, opc_jal}, 64'h3008);
    send_inst({7'h7f, 5'd3, 5'd4, 3'b011, 5'h1f, opc_store}, 64'h300c);

    // back-to-back mix with random ack delays
    set_forwarding(1'b1, $random(seed), random_word(), 1'b0, 1'b1, $random(seed), random_word());
    for (int n = 0; n < n_burst; n++) begin
      if ({$random(seed)} % 10 == 0) send_inst(random_inst(unknown_opcode()), random_word());
      else send_inst(random_inst(known_opc[{$random(seed)} % 11]), random_word() & ~64'h3);
    end

    wait_idle();
    repeat (2) @(posedge clk);
    $display("errors: %0d value mismatches, %0d protocol errors", mismatches, protocol_errs);
    if (mismatches == 0 && protocol_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    int delay;
    forever begin
      @(posedge clk);
      if (!reset_i && dec_req_o && !dec_ack_i) begin
        delay = {$random(seed)} % 6;
        repeat (delay) @(posedge clk);
        dec_ack_i <= 1'b1;
        do @(posedge clk); while (dec_req_o);
        dec_ack_i <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    bundle_t exp_b;
    if (!reset_i && dec_req_o && dec_ack_i) begin
      if (expected_q.size() == 0) begin
        protocol_errs++;
        $display("bundle issued at %0t with no instruction outstanding", $time);
      end else begin
        exp_b = expected_q.pop_front();
        check_equal(dec_class_o, exp_b.cls, "class");
        check_equal(dec_op_o, exp_b.op, "alu op");
        check_equal(dec_op1_o, exp_b.op1, "op1");
        check_equal(dec_op2_o, exp_b.op2, "op2");
        check_equal(dec_rd_we_o, exp_b.rd_we, "rd_we");
        check_equal(dec_rd_addr_o, exp_b.rd, "rd");
        check_equal(dec_pc_o, exp_b.pc, "pc");
        check_equal(dec_mem_size_o, exp_b.mem_size, "mem_size");
        check_equal(dec_mem_offset_o, exp_b.mem_offset, "mem_offset");
        check_equal(dec_jump_target_o, exp_b.jump_target, "jump_target");
        check_equal(dec_redirect_o, exp_b.redirect, "redirect");
      end
    end
  end

  // input side four-phase rule
  always @(posedge clk) begin
    if (reset_i) begin
      ack_prev <= 1'b0;
    end else begin
      if (inst_ack_o && !ack_prev && !inst_req_i) begin
        protocol_errs++;
        $display("inst_ack_o rose at %0t while inst_req_i was low", $time);
      end
      if (!inst_ack_o && ack_prev && inst_req_i) begin
        protocol_errs++;
        $display("inst_ack_o fell at %0t while inst_req_i was still high", $time);
      end
      ack_prev <= inst_ack_o;
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog timeout: the DUT stopped handshaking, %0d bundles never arrived",
             expected_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
